/* compile.f */
+incdir+hdl
hdl/vp_pkg.sv
hdl/vp_clock_enables.sv
hdl/vp_cart_loader.sv
hdl/vp_rom_addr_map.sv
hdl/vp_key_translator.sv
hdl/vp_palette.sv
hdl/vp_support_top.sv
tb/tb_clock_gen.sv
tb/tb_vp_support_top.sv

/* hdl/vp_cart_loader.sv */
`timescale 1ns/1ps
`include "vp_settings.svh"

module vp_cart_loader (
	input  logic clk_sys,
	input  logic reset,
	input  logic dl_active_i,
	input  logic dl_wr_i,
	input  vp_pkg::dl_index_t dl_index_i,
	output vp_pkg::img_size_t img_size_o,
	output logic xrom_o,
	output logic cart_load_o,
	output logic cart_we_o,
	output logic char_we_o
);

	import vp_pkg::*;

	logic dl_active_q;
	logic dl_rise;
	logic is_char;
	logic is_cart;
	img_size_t img_size_q;
	logic xrom_q;

	// Start of a new download
	assign dl_rise = dl_active_i & ~dl_active_q;

	// Font goes to the char store, indexes below it to the cart store
	assign is_char = (dl_index_i == dl_index_t'(`VP_IDX_CHAR));
	assign is_cart = (dl_index_i < dl_index_t'(`VP_IDX_CHAR));

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			dl_active_q <= 1'b0;
			img_size_q <= '0;
			xrom_q <= 1'b0;
		end else begin
			dl_active_q <= dl_active_i;
			if (dl_rise) begin
				// Fresh image, size restarts and XROM is decided once
				img_size_q <= '0;
				xrom_q <= (dl_index_i == dl_index_t'(`VP_IDX_XROM));
			end else if (dl_active_i && dl_wr_i) begin
				img_size_q <= img_size_q + 1'b1;
			end
		end
	end

	assign img_size_o = img_size_q;
	assign xrom_o = xrom_q;

	// Store strobes, no register stage
	assign cart_load_o = dl_active_i & is_cart;
	assign cart_we_o = dl_wr_i & is_cart;
	assign char_we_o = dl_wr_i & is_char;

	// Image larger than the counter would corrupt the bank layout
	a_size_no_wrap: assert property (
		@(posedge clk_sys) disable iff (reset)
		(dl_active_i && dl_wr_i && !dl_rise) |=> (img_size_o != '0)
	);

endmodule

/* hdl/vp_clock_enables.sv */
`timescale 1ns/1ps
`include "vp_settings.svh"

module vp_clock_enables (
	input  logic clk_sys,
	input  logic reset,
	input  logic pal_i,
	output logic cpu_en_o,
	output logic vdc_en_o
);

	// Channel 0 drives the CPU, channel 1 the VDC
	localparam logic [`VP_DIV_W-1:0] lim_ntsc_c [2] = '{`VP_CPU_LIM_NTSC, `VP_VDC_LIM_NTSC};
	localparam logic [`VP_DIV_W-1:0] lim_pal_c [2] = '{`VP_CPU_LIM_PAL, `VP_VDC_LIM_PAL};

	logic pal_q;
	logic std_chg;
	logic en_q [2];

	// Previous video standard
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			pal_q <= 1'b0;
		end else begin
			pal_q <= pal_i;
		end
	end

	// Standard switch restarts both dividers
	assign std_chg = pal_i ^ pal_q;

	for (genvar i = 0; i < 2; i++) begin : g_div
		logic [`VP_DIV_W-1:0] cnt_q;
		logic [`VP_DIV_W-1:0] lim;

		assign lim = pal_i ? lim_pal_c[i] : lim_ntsc_c[i];

		// Count 0..lim, pulse in the cycle after lim
		always_ff @(posedge clk_sys or posedge reset) begin
			if (reset) begin
				cnt_q <= '0;
				en_q[i] <= 1'b0;
			end else if (std_chg) begin
				cnt_q <= '0;
				en_q[i] <= 1'b0;
			end else if (cnt_q == lim) begin
				cnt_q <= '0;
				en_q[i] <= 1'b1;
			end else begin
				cnt_q <= cnt_q + 1'b1;
				en_q[i] <= 1'b0;
			end
		end

		// Enable is always a lone pulse, every limit is at least 1
		a_single_pulse: assert property (
			@(posedge clk_sys) disable iff (reset) en_q[i] |=> !en_q[i]
		);
	end

	assign cpu_en_o = en_q[0];
	assign vdc_en_o = en_q[1];

endmodule

/* hdl/vp_key_translator.sv */
`timescale 1ns/1ps

module vp_key_translator (
	input  logic clk_sys,
	input  logic reset,
	input  vp_pkg::ps2_key_t ps2_key_i,
	input  vp_pkg::numpad_t joy_a_numpad_i,
	input  vp_pkg::numpad_t joy_b_numpad_i,
	output logic rx_ready_o,
	output logic rx_released_o,
	output vp_pkg::ascii_t rx_ascii_o
);

	import vp_pkg::*;

	// Scan code set 2 to keymap character with the extended bit ignored
	function automatic ascii_t scan_to_ascii(input logic [7:0] code);
		ascii_t ch;
		case (code)
			8'h16: ch = "1";
			8'h1e: ch = "2";
			8'h26: ch = "3";
			8'h25: ch = "4";
			8'h2e: ch = "5";
			8'h36: ch = "6";
			8'h3d: ch = "7";
			8'h3e: ch = "8";
			8'h46: ch = "9";
			8'h45: ch = "0";
			8'h1c: ch = "a";
			8'h32: ch = "b";
			8'h21: ch = "c";
			8'h23: ch = "d";
			8'h24: ch = "e";
			8'h2b: ch = "f";
			8'h34: ch = "g";
			8'h33: ch = "h";
			8'h43: ch = "i";
			8'h3b: ch = "j";
			8'h42: ch = "k";
			8'h4b: ch = "l";
			8'h3a: ch = "m";
			8'h31: ch = "n";
			8'h44: ch = "o";
			8'h4d: ch = "p";
			8'h15: ch = "q";
			8'h2d: ch = "r";
			8'h1b: ch = "s";
			8'h2c: ch = "t";
			8'h3c: ch = "u";
			8'h2a: ch = "v";
			8'h1d: ch = "w";
			8'h22: ch = "x";
			8'h35: ch = "y";
			8'h1a: ch = "z";
			8'h29: ch = " ";
			8'h79: ch = "+";
			8'h7b: ch = "-";
			8'h7c: ch = "*";
			8'h4a: ch = "/";
			8'h55: ch = "=";
			// GUI keys act as yes / no
			8'h1f: ch = 8'h11;
			8'h27: ch = 8'h12;
			// Enter and backspace
			8'h5a: ch = 8'd10;
			8'h66: ch = 8'd8;
			default: ch = 8'h00;
		endcase
		return ch;
	endfunction

	// Lowest held button wins and bit 9 is digit 0
	function automatic ascii_t numpad_digit(input numpad_t pad);
		ascii_t ch;
		ch = 8'h00;
		for (int i = 9; i >= 0; i--) begin
			if (pad[i])
				ch = (i == 9) ? "0" : ascii_t'("1" + i);
		end
		return ch;
	endfunction

	numpad_t numpad;
	numpad_t numpad_q;
	logic toggle_q;
	logic ps2_chg;
	logic joy_chg;

	// Either joystick may press a digit
	assign numpad = joy_a_numpad_i | joy_b_numpad_i;
	assign ps2_chg = ps2_key_i[10] ^ toggle_q;
	assign joy_chg = (numpad != numpad_q);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			toggle_q <= 1'b0;
			numpad_q <= '0;
			rx_ready_o <= 1'b0;
			rx_released_o <= 1'b0;
			rx_ascii_o <= '0;
		end else begin
			toggle_q <= ps2_key_i[10];
			numpad_q <= numpad;
			rx_ready_o <= ps2_chg | joy_chg;
			// Release needs both the keyboard and the pads idle
			rx_released_o <= ~ps2_key_i[9] & ~(|numpad);
			rx_ascii_o <= ps2_chg ? scan_to_ascii(ps2_key_i[7:0]) : numpad_digit(numpad);
		end
	end

	// Every event traces back to an input edge
	a_ready_cause: assert property (
		@(posedge clk_sys) disable iff (reset)
		rx_ready_o |-> ($past(ps2_key_i[10]) != $past(ps2_key_i[10], 2)) ||
			($past(numpad) != $past(numpad, 2))
	);

endmodule

/* hdl/vp_palette.sv */
`timescale 1ns/1ps

module vp_palette (
	input  logic clk_sys,
	input  logic reset,
	input  logic [3:0] colour_code_i,
	input  logic rgb_mode_i,
	input  logic mono_i,
	output vp_pkg::rgb_t colour_o
);

	import vp_pkg::*;

	rgb_t colour_sel;
	logic [7:0] red;
	logic [7:0] green;
	logic [7:0] blue;
	logic [15:0] grey_sum;
	logic [7:0] grey;

	////////////////////////////////////////////////////////////
	// Table lookup
	////////////////////////////////////////////////////////////

	// Code is {R, G, B, luma} straight from the VDC
	assign colour_sel = rgb_mode_i ? pal_rgb_c[colour_code_i] : pal_tv_c[colour_code_i];

	assign red = colour_sel[23:16];
	assign green = colour_sel[15:8];
	assign blue = colour_sel[7:0];

	////////////////////////////////////////////////////////////
	// Black and white TV
	////////////////////////////////////////////////////////////

	// Luma weights in 1/256 units, sum is 256
	// Peak 255 * 256 still fits in 16 bits
	assign grey_sum = 16'd77 * red + 16'd150 * green + 16'd29 * blue;
	assign grey = grey_sum[15:8];

	// Single register stage to the video output
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			colour_o <= '0;
		end else if (mono_i) begin
			colour_o <= {grey, grey, grey};
		end else begin
			colour_o <= colour_sel;
		end
	end

endmodule

/* hdl/vp_pkg.sv */
package vp_pkg;

	// Console side addresses
	typedef logic [11:0] cart_addr_t;
	typedef logic [13:0] rom_addr_t;
	typedef logic [8:0] char_addr_t;

	// Host download side
	typedef logic [24:0] dl_addr_t;
	typedef logic [7:0] dl_index_t;
	typedef logic [15:0] img_size_t;

	// Key record: toggle, pressed, extended, scan code
	typedef logic [10:0] ps2_key_t;
	// Joystick numpad buttons, digits 1..9 then 0
	typedef logic [9:0] numpad_t;
	typedef logic [7:0] ascii_t;

	// Red in the top byte
	typedef logic [23:0] rgb_t;

	////////////////////////////////////////////////////////////
	// Palettes, indexed by {R, G, B, luma}
	////////////////////////////////////////////////////////////

	// Calibrated RF television colours
	localparam rgb_t pal_tv_c [16] = '{
		24'h000000, 24'h676767,
		24'h1a37be, 24'h5c80f6,
		24'h006d07, 24'h56c469,
		24'h2aaabe, 24'h77e6eb,
		24'h790000, 24'hc75151,
		24'h94309f, 24'hdc84e8,
		24'h77670b, 24'hc6b86a,
		24'hcecece, 24'hffffff
	};

	// Saturated RGB monitor colours
	localparam rgb_t pal_rgb_c [16] = '{
		24'h000000, 24'h494949,
		24'h0000b6, 24'h4949ff,
		24'h00b601, 24'h49ff49,
		24'h00b6c9, 24'h49ffff,
		24'hb60000, 24'hff4949,
		24'hb600b6, 24'hff49ff,
		24'hb6b600, 24'hffff49,
		24'hb6b6b6, 24'hffffff
	};

endpackage

/* hdl/vp_rom_addr_map.sv */
`timescale 1ns/1ps
`include "vp_settings.svh"

module vp_rom_addr_map (
	input  logic cart_load_i,
	input  logic xrom_i,
	input  vp_pkg::img_size_t img_size_i,
	input  vp_pkg::dl_addr_t dl_addr_i,
	input  vp_pkg::cart_addr_t cart_addr_i,
	input  logic bs0_i,
	input  logic bs1_i,
	input  logic cs_n_i,
	input  logic psen_n_i,
	output vp_pkg::rom_addr_t rom_addr_o,
	output logic rom_rden_o
);

	import vp_pkg::*;

	rom_addr_t map_addr;

	////////////////////////////////////////////////////////////
	// Bank layout by image size
	////////////////////////////////////////////////////////////

	// Address bit 10 is not decoded by the cart slot except on XROM and 16K
	always_comb begin
		if (xrom_i) begin
			map_addr = {2'b00, cart_addr_i};
		end else begin
			case (img_size_i)
				img_size_t'(`VP_SIZE_4K):
					map_addr = {2'b00, bs0_i, cart_addr_i[11], cart_addr_i[9:0]};
				img_size_t'(`VP_SIZE_8K):
					map_addr = {1'b0, bs1_i, bs0_i, cart_addr_i[11], cart_addr_i[9:0]};
				// 12K images are stored padded to 16K
				img_size_t'(`VP_SIZE_16K):
					map_addr = {bs1_i, bs0_i, cart_addr_i};
				default:
					map_addr = {3'b000, cart_addr_i[11], cart_addr_i[9:0]};
			endcase
		end
	end

	// Host download owns the store address while loading
	assign rom_addr_o = cart_load_i ? dl_addr_i[13:0] : map_addr;

	// XROM reads on psen high unless the cart select and bank 0 line are both high
	assign rom_rden_o = xrom_i ? (psen_n_i & ~(cs_n_i & bs0_i)) : ~psen_n_i;

endmodule

/* hdl/vp_settings.svh */
`ifndef VP_SETTINGS_SVH
`define VP_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Clock divider limits, last count before wrap
////////////////////////////////////////////////////////////

// CPU enable, 8 and 12 clk_sys periods
`define VP_CPU_LIM_NTSC 7
`define VP_CPU_LIM_PAL 11
// VDC enable, 6 and 10 clk_sys periods
`define VP_VDC_LIM_NTSC 5
`define VP_VDC_LIM_PAL 9
// Divider counter width
`define VP_DIV_W 4

////////////////////////////////////////////////////////////
// Download indexes and image sizes
////////////////////////////////////////////////////////////

// Index 2 loads an XROM image
`define VP_IDX_XROM 2
// Index 3 loads the VDC character font
`define VP_IDX_CHAR 3
// Sizes that select a bank layout
`define VP_SIZE_4K 4096
`define VP_SIZE_8K 8192
`define VP_SIZE_16K 16384

`endif

/* hdl/vp_support_top.sv */
`timescale 1ns/1ps

module vp_support_top (
	input  logic clk_sys,
	input  logic reset,
	input  logic pal_i,
	input  logic rgb_mode_i,
	input  logic mono_i,
	input  logic dl_active_i,
	input  logic dl_wr_i,
	input  vp_pkg::dl_index_t dl_index_i,
	input  vp_pkg::dl_addr_t dl_addr_i,
	input  vp_pkg::cart_addr_t cart_addr_i,
	input  logic bs0_i,
	input  logic bs1_i,
	input  logic cs_n_i,
	input  logic psen_n_i,
	input  vp_pkg::ps2_key_t ps2_key_i,
	input  vp_pkg::numpad_t joy_a_numpad_i,
	input  vp_pkg::numpad_t joy_b_numpad_i,
	input  logic [3:0] colour_code_i,
	output logic cpu_en_o,
	output logic vdc_en_o,
	output logic cart_we_o,
	output logic char_we_o,
	output vp_pkg::char_addr_t char_addr_o,
	output vp_pkg::rom_addr_t rom_addr_o,
	output logic rom_rden_o,
	output logic rx_ready_o,
	output vp_pkg::ascii_t rx_ascii_o,
	output logic rx_released_o,
	output vp_pkg::rgb_t colour_o
);

	import vp_pkg::*;

	// Loader state seen by the address mapper
	img_size_t img_size;
	logic xrom;
	logic cart_load;

	////////////////////////////////////////////////////////////
	// Clocking and cartridge store
	////////////////////////////////////////////////////////////

	vp_clock_enables i_vp_clock_enables (
		.clk_sys (clk_sys),
		.reset (reset),
		.pal_i (pal_i),
		.cpu_en_o (cpu_en_o),
		.vdc_en_o (vdc_en_o)
	);

	vp_cart_loader i_vp_cart_loader (
		.clk_sys (clk_sys),
		.reset (reset),
		.dl_active_i (dl_active_i),
		.dl_wr_i (dl_wr_i),
		.dl_index_i (dl_index_i),
		.img_size_o (img_size),
		.xrom_o (xrom),
		.cart_load_o (cart_load),
		.cart_we_o (cart_we_o),
		.char_we_o (char_we_o)
	);

	vp_rom_addr_map i_vp_rom_addr_map (
		.cart_load_i (cart_load),
		.xrom_i (xrom),
		.img_size_i (img_size),
		.dl_addr_i (dl_addr_i),
		.cart_addr_i (cart_addr_i),
		.bs0_i (bs0_i),
		.bs1_i (bs1_i),
		.cs_n_i (cs_n_i),
		.psen_n_i (psen_n_i),
		.rom_addr_o (rom_addr_o),
		.rom_rden_o (rom_rden_o)
	);

	// Font store is only written from the host, 512 bytes
	assign char_addr_o = dl_addr_i[8:0];

	////////////////////////////////////////////////////////////
	// Keyboard and video colour
	////////////////////////////////////////////////////////////

	vp_key_translator i_vp_key_translator (
		.clk_sys (clk_sys),
		.reset (reset),
		.ps2_key_i (ps2_key_i),
		.joy_a_numpad_i (joy_a_numpad_i),
		.joy_b_numpad_i (joy_b_numpad_i),
		.rx_ready_o (rx_ready_o),
		.rx_released_o (rx_released_o),
		.rx_ascii_o (rx_ascii_o)
	);

	vp_palette i_vp_palette (
		.clk_sys (clk_sys),
		.reset (reset),
		.colour_code_i (colour_code_i),
		.rgb_mode_i (rgb_mode_i),
		.mono_i (mono_i),
		.colour_o (colour_o)
	);

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk_sys,
	output logic reset
);

	// 8 ns period
	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// Eight rising edges in reset, released just after an edge
	initial begin
		reset = 1'b1;
		repeat (8) @(posedge clk_sys);
		#1 reset = 1'b0;
	end

endmodule

/* tb/tb_vp_support_top.sv */
`timescale 1ns/1ps
`include "vp_settings.svh"

module tb_vp_support_top;

	import vp_pkg::*;

	// Clock test, downloads with sweeps, keys, pads and palette
	localparam int dl_bytes_c = 4096 + 8192 + 16384 + 2048 + 4096 + 512;
	localparam int test_cycles_c = 150 + dl_bytes_c + 6 * 40 + 8 + 80 + 140 + 70;
	localparam int limit_c = 2 * test_cycles_c;

	// Scan code set 2 and the matching keymap characters
	localparam logic [7:0] key_code_c [46] = '{
		8'h16, 8'h1e, 8'h26, 8'h25, 8'h2e, 8'h36, 8'h3d, 8'h3e, 8'h46, 8'h45,
		8'h1c, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2b, 8'h34, 8'h33, 8'h43, 8'h3b,
		8'h42, 8'h4b, 8'h3a, 8'h31, 8'h44, 8'h4d, 8'h15, 8'h2d, 8'h1b, 8'h2c,
		8'h3c, 8'h2a, 8'h1d, 8'h22, 8'h35, 8'h1a, 8'h29, 8'h79, 8'h7b, 8'h7c,
		8'h4a, 8'h55, 8'h1f, 8'h27, 8'h5a, 8'h66
	};
	localparam logic [7:0] key_char_c [46] = '{
		"1", "2", "3", "4", "5", "6", "7", "8", "9", "0",
		"a", "b", "c", "d", "e", "f", "g", "h", "i", "j",
		"k", "l", "m", "n", "o", "p", "q", "r", "s", "t",
		"u", "v", "w", "x", "y", "z", " ", "+", "-", "*",
		"/", "=", 8'h11, 8'h12, 8'd10, 8'd8
	};

	logic clk_sys, reset;
	logic pal_i, rgb_mode_i, mono_i, dl_active_i, dl_wr_i;
	logic bs0_i, bs1_i, cs_n_i, psen_n_i;
	dl_index_t dl_index_i;
	dl_addr_t dl_addr_i;
	cart_addr_t cart_addr_i;
	ps2_key_t ps2_key_i;
	numpad_t joy_a_numpad_i, joy_b_numpad_i;
	logic [3:0] colour_code_i;
	logic cpu_en_o, vdc_en_o, cart_we_o, char_we_o, rom_rden_o;
	logic rx_ready_o, rx_released_o;
	char_addr_t char_addr_o;
	rom_addr_t rom_addr_o;
	ascii_t rx_ascii_o;
	rgb_t colour_o;

	// Model state valid after the next rising edge
	logic m_valid, m_active_q, m_xrom, m_toggle, m_ready, m_released;
	img_size_t m_size;
	numpad_t m_numpad;
	ascii_t m_ascii;
	rgb_t m_colour;
	int last_cpu, last_vdc, cpu_checks, vdc_checks, cycle_cnt;
	logic per_chk;
	int err_cnt, test_err_base, pass_cnt, fail_cnt;
	logic [31:0] rng_state, r;

	tb_clock_gen i_tb_clock_gen (.clk_sys (clk_sys), .reset (reset));

	vp_support_top i_vp_support_top (.*);

	////////////////////////////////////////////////////////////
	// Reference functions
	////////////////////////////////////////////////////////////

	function automatic int period_ref(input logic pal, input logic is_cpu);
		if (is_cpu)
			return (pal ? `VP_CPU_LIM_PAL : `VP_CPU_LIM_NTSC) + 1;
		return (pal ? `VP_VDC_LIM_PAL : `VP_VDC_LIM_NTSC) + 1;
	endfunction

	// Bank number times bank size plus the offset inside the bank
	function automatic rom_addr_t addr_ref(input logic load, input logic xrom,
		input img_size_t size, input dl_addr_t dl, input cart_addr_t ca, input logic bs0,
		input logic bs1);
		int low;
		low = ca[11] * 1024 + ca[9:0];
		if (load)
			return dl[13:0];
		if (xrom)
			return rom_addr_t'(ca);
		case (int'(size))
			4096: return rom_addr_t'(bs0 * 2048 + low);
			8192: return rom_addr_t'((bs1 * 2 + bs0) * 2048 + low);
			16384: return rom_addr_t'((bs1 * 2 + bs0) * 4096 + ca);
			default: return rom_addr_t'(low);
		endcase
	endfunction

	function automatic logic rden_ref(input logic xrom, input logic psen_n, input logic cs_n,
		input logic bs0);
		return xrom ? (psen_n && !(cs_n && bs0)) : !psen_n;
	endfunction

	function automatic ascii_t ascii_ref(input logic [7:0] code);
		for (int i = 0; i < 46; i++)
			if (key_code_c[i] == code)
				return key_char_c[i];
		return 8'h00;
	endfunction

	// Bit 0 is digit 1, bit 9 is digit 0
	function automatic ascii_t digit_ref(input numpad_t pad);
		for (int i = 0; i < 10; i++)
			if (pad[i])
				return (i == 9) ? "0" : ascii_t'(8'h31 + i);
		return 8'h00;
	endfunction

	function automatic rgb_t colour_ref(input logic [3:0] code, input logic rgb, input logic mono);
		rgb_t c;
		int g;
		c = rgb ? pal_rgb_c[code] : pal_tv_c[code];
		g = (77 * c[23:16] + 150 * c[15:8] + 29 * c[7:0]) / 256;
		return mono ? {g[7:0], g[7:0], g[7:0]} : c;
	endfunction

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	////////////////////////////////////////////////////////////
	// Comparison at the falling edge where inputs and outputs are settled
	////////////////////////////////////////////////////////////

	always @(negedge clk_sys) begin : compare_outputs
		logic load;
		logic ps2_chg;
		numpad_t pad;
		if (reset) begin
			m_valid = 1'b0;
			m_active_q = 1'b0;
			m_size = '0;
			m_xrom = 1'b0;
			m_toggle = 1'b0;
			m_numpad = '0;
			last_cpu = -1;
			last_vdc = -1;
		end else begin
			// Registered outputs against the previous prediction
			if (m_valid) begin
				assert (rx_ready_o === m_ready && rx_ascii_o === m_ascii &&
					rx_released_o === m_released) else begin
					$display("error %0t: key event %b/%h/%b expected %b/%h/%b", $time, rx_ready_o,
						rx_ascii_o, rx_released_o, m_ready, m_ascii, m_released);
					err_cnt++;
				end
				assert (colour_o === m_colour) else begin
					$display("error %0t: colour %h expected %h", $time, colour_o, m_colour);
					err_cnt++;
				end
			end
			// Combinational address and store strobes
			load = dl_active_i && (dl_index_i < `VP_IDX_CHAR);
			assert (rom_addr_o === addr_ref(load, m_xrom, m_size, dl_addr_i, cart_addr_i, bs0_i,
				bs1_i) && rom_rden_o === rden_ref(m_xrom, psen_n_i, cs_n_i, bs0_i)) else begin
				$display("error %0t: rom address %h read %b at size %0d", $time, rom_addr_o,
					rom_rden_o, m_size);
				err_cnt++;
			end
			assert (cart_we_o === (dl_wr_i && dl_index_i < `VP_IDX_CHAR) &&
				char_we_o === (dl_wr_i && dl_index_i == `VP_IDX_CHAR) &&
				char_addr_o === dl_addr_i[8:0]) else begin
				$display("error %0t: write routing cart %b char %b", $time, cart_we_o, char_we_o);
				err_cnt++;
			end
			// Enable spacing in clk_sys cycles
			if (cpu_en_o) begin
				if (per_chk && last_cpu >= 0) begin
					cpu_checks++;
					assert (cycle_cnt - last_cpu == period_ref(pal_i, 1'b1)) else begin
						$display("error %0t: cpu enable spacing %0d", $time, cycle_cnt - last_cpu);
						err_cnt++;
					end
				end
				last_cpu = cycle_cnt;
			end
			if (vdc_en_o) begin
				if (per_chk && last_vdc >= 0) begin
					vdc_checks++;
					assert (cycle_cnt - last_vdc == period_ref(pal_i, 1'b0)) else begin
						$display("error %0t: vdc enable spacing %0d", $time, cycle_cnt - last_vdc);
						err_cnt++;
					end
				end
				last_vdc = cycle_cnt;
			end
			// What the next edge should produce
			ps2_chg = ps2_key_i[10] != m_toggle;
			pad = joy_a_numpad_i | joy_b_numpad_i;
			m_ready = ps2_chg || (pad != m_numpad);
			m_ascii = ps2_chg ? ascii_ref(ps2_key_i[7:0]) : digit_ref(pad);
			m_released = !ps2_key_i[9] && (pad == '0);
			m_toggle = ps2_key_i[10];
			m_numpad = pad;
			m_colour = colour_ref(colour_code_i, rgb_mode_i, mono_i);
			if (dl_active_i && !m_active_q) begin
				m_size = '0;
				m_xrom = (dl_index_i == `VP_IDX_XROM);
			end else if (dl_active_i && dl_wr_i) begin
				m_size = m_size + 1'b1;
			end
			m_active_q = dl_active_i;
			m_valid = 1'b1;
		end
	end

	// Run length guard
	always @(posedge clk_sys) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= limit_c) begin
			$display("timeout: simulation still running after %0d cycles", limit_c);
			$display("tests failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	// Inputs change 1 ns after the rising edge
	task next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task wait_cpu_pulse();
		do
			@(negedge clk_sys);
		while (!cpu_en_o);
	endtask

	// Active one cycle ahead of the first byte so the size starts clean
	task download(input int index, input int nbytes);
		next_cycle();
		dl_index_i = dl_index_t'(index);
		dl_active_i = 1'b1;
		for (int i = 0; i < nbytes; i++) begin
			next_cycle();
			dl_wr_i = 1'b1;
			dl_addr_i = dl_addr_t'(next_rand());
		end
		next_cycle();
		dl_wr_i = 1'b0;
		dl_active_i = 1'b0;
	endtask

	task random_cart_access(input int n);
		repeat (n) begin
			next_cycle();
			r = next_rand();
			cart_addr_i = r[11:0];
			bs0_i = r[12];
			bs1_i = r[13];
			cs_n_i = r[14];
			psen_n_i = r[15];
		end
	endtask

	task report_test(input string name);
		if (err_cnt == test_err_base) begin
			pass_cnt++;
			$display("test %s: ok", name);
		end else begin
			fail_cnt++;
			$display("test %s: %0d errors", name, err_cnt - test_err_base);
		end
		test_err_base = err_cnt;
	endtask

	initial begin
		rng_state = 32'd45;
		{pal_i, rgb_mode_i, mono_i, dl_active_i, dl_wr_i} = '0;
		{bs0_i, bs1_i, cs_n_i, psen_n_i} = '0;
		dl_index_i = '0;
		dl_addr_i = '0;
		cart_addr_i = '0;
		ps2_key_i = '0;
		joy_a_numpad_i = '0;
		joy_b_numpad_i = '0;
		colour_code_i = '0;
		per_chk = 1'b0;
		@(negedge reset);
		next_cycle();

		// NTSC spacing, then PAL after the restart pulse
		wait_cpu_pulse();
		next_cycle();
		per_chk = 1'b1;
		repeat (6) wait_cpu_pulse();
		next_cycle();
		per_chk = 1'b0;
		pal_i = 1'b1;
		wait_cpu_pulse();
		next_cycle();
		per_chk = 1'b1;
		repeat (6) wait_cpu_pulse();
		next_cycle();
		per_chk = 1'b0;
		// 48 NTSC cycles hold 8 VDC pulses and 72 PAL cycles after the restart hold 7
		assert (cpu_checks == 12 && vdc_checks == 15) else begin
			$display("measured %0d cpu and %0d vdc enable spacings instead of 12 and 15",
				cpu_checks, vdc_checks);
			err_cnt++;
		end
		report_test("clock enables");

		// Plain cartridge layouts
		download(1, `VP_SIZE_4K);
		random_cart_access(40);
		download(1, `VP_SIZE_8K);
		random_cart_access(40);
		download(1, `VP_SIZE_16K);
		random_cart_access(40);
		download(1, 2048);
		random_cart_access(40);
		report_test("image sizes");

		// XROM layout, then the font goes to the char store only
		download(`VP_IDX_XROM, `VP_SIZE_4K);
		random_cart_access(40);
		download(`VP_IDX_CHAR, 512);
		random_cart_access(40);
		report_test("xrom and routing");

		// Mapped and unmapped codes with one idle cycle per key
		repeat (40) begin
			next_cycle();
			r = next_rand();
			ps2_key_i[10] = ~ps2_key_i[10];
			ps2_key_i[9] = r[8];
			ps2_key_i[8] = r[9];
			ps2_key_i[7:0] = r[10] ? key_code_c[r[31:16] % 46] : r[7:0];
			next_cycle();
		end
		report_test("ps2 keys");

		// Keyboard released first so only the pads hold the key
		next_cycle();
		ps2_key_i[10] = ~ps2_key_i[10];
		ps2_key_i[9] = 1'b0;
		repeat (40) begin
			next_cycle();
			r = next_rand();
			joy_a_numpad_i = r[9:0] & r[25:16];
			joy_b_numpad_i = r[19:10] & r[31:22];
			next_cycle();
			if (r[30]) begin
				joy_a_numpad_i = '0;
				joy_b_numpad_i = '0;
				next_cycle();
			end
		end
		// Pressed keyboard keeps released low after the pads clear
		ps2_key_i[10] = ~ps2_key_i[10];
		ps2_key_i[9] = 1'b1;
		next_cycle();
		joy_b_numpad_i = 10'h200;
		next_cycle();
		joy_a_numpad_i = '0;
		joy_b_numpad_i = '0;
		next_cycle();
		report_test("joystick numpad");

		// Every code in TV and RGB, colour and mono
		for (int m = 0; m < 4; m++) begin
			for (int c = 0; c < 16; c++) begin
				next_cycle();
				rgb_mode_i = m[0];
				mono_i = m[1];
				colour_code_i = c[3:0];
			end
		end
		next_cycle();
		next_cycle();
		report_test("palette");

		$display("summary: %0d passed, %0d failed, %0d errors", pass_cnt, fail_cnt, err_cnt);
		if (fail_cnt == 0 && err_cnt == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule
